// File: Bender.yml
package:
  name: trigger_capture

sources:
  - include_dirs:
      - hw
    files:
      - hw/capture_pkg.sv
      - hw/window_if.sv
      - hw/ptr_fifo.sv
      - hw/window_tracker.sv
      - hw/sample_ring.sv
      - hw/lane_streamer.sv
      - hw/trigger_capture.sv
  - target: test
    files:
      - verification/trigger_capture_chk.sv
      - verification/trigger_capture_tb.sv

// File: hw/capture_pkg.sv
`include "capture_settings.svh"

package capture_pkg;

  // index into the sample ring
  typedef logic [$clog2(`CAP_RING_DEPTH)-1:0] ring_ptr_t;

  // lane position inside one sample word
  typedef logic [$clog2(`CAP_LANES)-1:0] lane_idx_t;

  typedef logic [`CAP_DOUT_WIDTH-1:0] lane_t;

  // one sample word, either as stored or split into output lanes
  // lanes[0] holds the low bits and goes out first
  typedef union packed {
    logic [`CAP_DIN_WIDTH-1:0] raw;
    lane_t [`CAP_LANES-1:0] lanes;
  } sample_word_t;

endpackage

// File: hw/capture_settings.svh
`ifndef CAPTURE_SETTINGS_SVH
`define CAPTURE_SETTINGS_SVH

// input sample word width
`define CAP_DIN_WIDTH 64

// output lane width
`define CAP_DOUT_WIDTH 16

`define CAP_LANES (`CAP_DIN_WIDTH / `CAP_DOUT_WIDTH)

`define CAP_RING_DEPTH 32 // words in the sample ring

`define CAP_PRE_LEN 4 // pre-trigger words kept per window

`define CAP_WIN_DEPTH 4 // pending windows per pointer fifo

`endif

// File: hw/lane_streamer.sv
`include "capture_settings.svh"

module lane_streamer (
  input logic CLK,
  input logic RESET,
  window_if.reader win,
  input capture_pkg::sample_word_t rd_word,
  output capture_pkg::ring_ptr_t rd_ptr,
  output capture_pkg::lane_t dout,
  output logic first_flag,
  output logic last_flag,
  output logic done
);
  import capture_pkg::*;

  logic busy; // window being walked, including the drain after its end
  logic active; // addresses still to issue
  logic first_pend;
  lane_idx_t phase;
  ring_ptr_t rd_next;
  logic issue;
  logic issue_q;
  logic first_q;
  logic last_q;
  logic last_word;
  lane_idx_t lane;
  sample_word_t word_q;

  assign rd_next = (rd_ptr == ring_ptr_t'(`CAP_RING_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  // only start once the window's end is known, so reads never pass the writer
  assign win.start_take = !busy && win.start_valid && win.end_valid &&
                          (rd_ptr == win.last_end_ptr);

  assign issue = active && (phase == '0); // one address per word
  assign win.end_take = issue && win.end_valid && (rd_next == win.end_ptr);

  assign dout = word_q.lanes[lane];

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      busy <= 1'b0;
      active <= 1'b0;
      first_pend <= 1'b0;
      phase <= '0;
      rd_ptr <= '0;
    end else if (win.start_take) begin
      busy <= 1'b1;
      active <= 1'b1;
      first_pend <= 1'b1;
      phase <= '0;
      rd_ptr <= win.start_ptr;
    end else if (busy) begin
      phase <= phase + 1'b1;
      if (issue) begin
        rd_ptr <= rd_next;
        first_pend <= 1'b0;
      end
      if (win.end_take) begin
        active <= 1'b0;
      end
      // let the last word drain before the next start, keeps a done gap
      if (!active && (phase == lane_idx_t'(`CAP_LANES - 1))) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      issue_q <= 1'b0;
      first_q <= 1'b0;
      last_q <= 1'b0;
      last_word <= 1'b0;
      lane <= '0;
      done <= 1'b1;
      first_flag <= 1'b0;
      last_flag <= 1'b0;
    end else begin
      issue_q <= issue; // rd_word valid next cycle
      first_q <= issue && first_pend;
      last_q <= win.end_take;
      first_flag <= issue_q && first_q;
      last_flag <= !done && last_word && (lane == lane_idx_t'(`CAP_LANES - 2));
      if (issue_q) begin
        lane <= '0;
        done <= 1'b0;
        last_word <= last_q;
      end else if (!done) begin
        lane <= lane + 1'b1;
        if (lane == lane_idx_t'(`CAP_LANES - 1)) begin
          done <= 1'b1; // no word followed
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (issue_q) begin
      word_q <= rd_word;
    end
  end

endmodule

// File: hw/ptr_fifo.sv
`include "capture_settings.svh"

module ptr_fifo (
  input logic CLK,
  input logic RESET,
  input capture_pkg::ring_ptr_t din,
  input logic push,
  input logic pop,
  output capture_pkg::ring_ptr_t dout,
  output logic empty,
  output logic full
);
  import capture_pkg::*;

  localparam int IDX_W = $clog2(`CAP_WIN_DEPTH);

  ring_ptr_t mem [`CAP_WIN_DEPTH];
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic [IDX_W:0] count;
  logic do_push;
  logic do_pop;

  assign do_push = push && !full; // dropped when full
  assign do_pop = pop && !empty;

  assign empty = (count == '0);
  assign full = (count == (IDX_W + 1)'(`CAP_WIN_DEPTH));
  assign dout = mem[rd_idx]; // head shown straight from memory

  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem[wr_idx] <= din;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      wr_idx <= '0;
      rd_idx <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        wr_idx <= (wr_idx == IDX_W'(`CAP_WIN_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
      end
      if (do_pop) begin
        rd_idx <= (rd_idx == IDX_W'(`CAP_WIN_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hw/sample_ring.sv
`include "capture_settings.svh"

module sample_ring (
  input logic CLK,
  input logic RESET,
  input logic we,
  input capture_pkg::sample_word_t din,
  input capture_pkg::ring_ptr_t rd_ptr,
  output capture_pkg::sample_word_t rd_word,
  output capture_pkg::ring_ptr_t wr_ptr,
  input logic pending,
  output logic full,
  output logic empty
);
  import capture_pkg::*;

  sample_word_t mem [`CAP_RING_DEPTH];
  ring_ptr_t wr_next;
  logic accept;

  assign accept = we && !full;
  assign wr_next = (wr_ptr == ring_ptr_t'(`CAP_RING_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

  always_ff @(posedge CLK) begin
    if (accept) begin
      mem[wr_ptr] <= din;
    end
    rd_word <= mem[rd_ptr]; // one cycle after the address
  end

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      wr_ptr <= '0;
      full <= 1'b0;
      empty <= 1'b0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_next;
      end

      // held until every window is out, then pre-trigger data overwrites freely
      if (!pending) begin
        full <= 1'b0;
      end else if (wr_next == rd_ptr) begin
        full <= 1'b1;
      end

      empty <= (wr_ptr == rd_ptr);
    end
  end

endmodule

// File: hw/trigger_capture.sv
`include "capture_settings.svh"

module trigger_capture (
  input logic CLK,
  input logic RESET,
  input logic we,
  input logic trigger,
  input logic [`CAP_DIN_WIDTH-1:0] din,
  output logic [`CAP_DOUT_WIDTH-1:0] dout,
  output logic first_flag,
  output logic last_flag,
  output logic done,
  output logic full,
  output logic empty
);
  import capture_pkg::*;

  window_if win ();

  ring_ptr_t wr_ptr;
  ring_ptr_t rd_ptr;
  sample_word_t rd_word;
  logic pending;

  window_tracker u_tracker (
    .CLK(CLK),
    .RESET(RESET),
    .trigger(trigger),
    .wr_ptr(wr_ptr),
    .win(win.tracker),
    .pending(pending)
  );

  sample_ring u_ring (
    .CLK(CLK),
    .RESET(RESET),
    .we(we),
    .din(din),
    .rd_ptr(rd_ptr),
    .rd_word(rd_word),
    .wr_ptr(wr_ptr),
    .pending(pending),
    .full(full),
    .empty(empty)
  );

  lane_streamer u_streamer (
    .CLK(CLK),
    .RESET(RESET),
    .win(win.reader),
    .rd_word(rd_word),
    .rd_ptr(rd_ptr),
    .dout(dout),
    .first_flag(first_flag),
    .last_flag(last_flag),
    .done(done)
  );

endmodule

// File: hw/window_if.sv
interface window_if;
  import capture_pkg::*;

  ring_ptr_t start_ptr; // head of the start fifo
  logic start_valid;
  ring_ptr_t end_ptr; // head of the end fifo, exclusive
  logic end_valid;
  ring_ptr_t last_end_ptr; // end of the window read last
  logic start_take; // pops the start head
  logic end_take; // pops the end head

  modport tracker (
    output start_ptr,
    output start_valid,
    output end_ptr,
    output end_valid,
    output last_end_ptr,
    input start_take,
    input end_take
  );

  modport reader (
    input start_ptr,
    input start_valid,
    input end_ptr,
    input end_valid,
    input last_end_ptr,
    output start_take,
    output end_take
  );

endinterface

// File: hw/window_tracker.sv
`include "capture_settings.svh"

module window_tracker (
  input logic CLK,
  input logic RESET,
  input logic trigger,
  input capture_pkg::ring_ptr_t wr_ptr,
  window_if.tracker win,
  output logic pending
);
  import capture_pkg::*;

  localparam int CNT_W = $clog2(`CAP_PRE_LEN + 1);

  logic trig_q;
  logic rise;
  logic fall;
  logic rise_q;
  ring_ptr_t wr_ptr_q;
  logic wrote; // ring took a word on the previous edge
  logic [CNT_W-1:0] pre_cnt;
  logic [CNT_W-1:0] pre_cnt_next;
  ring_ptr_t pre_back;
  ring_ptr_t start_now;
  ring_ptr_t start_calc;
  ring_ptr_t last_end;
  logic start_empty;
  logic end_empty;

  assign rise = trigger && !trig_q;
  assign fall = !trigger && trig_q;
  assign wrote = (wr_ptr != wr_ptr_q);

  // words written since the last window end, saturating
  assign pre_cnt_next = (pre_cnt == CNT_W'(`CAP_PRE_LEN)) ? pre_cnt
                                                          : pre_cnt + CNT_W'(wrote);

  // step back over the pre-trigger words, wrapping below zero
  assign pre_back = ring_ptr_t'(pre_cnt_next);
  assign start_now = (wr_ptr >= pre_back) ? wr_ptr - pre_back
                                          : ring_ptr_t'(`CAP_RING_DEPTH - pre_back + wr_ptr);

  always_ff @(posedge CLK) begin
    if (!RESET) begin
      trig_q <= 1'b0;
      rise_q <= 1'b0;
      wr_ptr_q <= '0;
      pre_cnt <= '0;
      last_end <= '0;
    end else begin
      trig_q <= trigger;
      rise_q <= rise; // start push waits one cycle for start_calc
      wr_ptr_q <= wr_ptr;
      if (fall) begin
        pre_cnt <= '0; // window closes here
      end else begin
        pre_cnt <= pre_cnt_next;
      end
      if (win.end_take) begin
        last_end <= win.end_ptr;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (rise) begin
      start_calc <= start_now;
    end
  end

  ptr_fifo u_start_fifo (
    .CLK(CLK),
    .RESET(RESET),
    .din(start_calc),
    .push(rise_q),
    .pop(win.start_take),
    .dout(win.start_ptr),
    .empty(start_empty),
    .full()
  );

  // end is the write pointer at the falling edge, exclusive
  ptr_fifo u_end_fifo (
    .CLK(CLK),
    .RESET(RESET),
    .din(wr_ptr),
    .push(fall),
    .pop(win.end_take),
    .dout(win.end_ptr),
    .empty(end_empty),
    .full()
  );

  assign win.start_valid = !start_empty;
  assign win.end_valid = !end_empty;
  assign win.last_end_ptr = last_end;

  // a window is open, queued or still being read
  assign pending = trig_q || !start_empty || !end_empty;

endmodule

// File: src.f
+incdir+hw
hw/capture_pkg.sv
hw/window_if.sv
hw/ptr_fifo.sv
hw/window_tracker.sv
hw/sample_ring.sv
hw/lane_streamer.sv
hw/trigger_capture.sv
verification/trigger_capture_chk.sv
verification/trigger_capture_tb.sv

// File: verification/trigger_capture_chk.sv
module trigger_capture_chk (
  input logic CLK,
  input logic RESET,
  input logic fifo_push,
  input logic fifo_full,
  input logic first_flag,
  input logic last_flag,
  input logic done
);

  a_no_push_full: assert property (@(posedge CLK) disable iff (!RESET)
    !(fifo_push && fifo_full))
    else $error("push into a full pointer fifo");

  a_flags_in_stream: assert property (@(posedge CLK) disable iff (!RESET)
    (first_flag || last_flag) |-> !done)
    else $error("lane flag while done is high");

  // stream opens with its first lane
  a_first_on_start: assert property (@(posedge CLK) disable iff (!RESET)
    $fell(done) |-> first_flag)
    else $error("done fell without first_flag");

  a_done_gap: assert property (@(posedge CLK) disable iff (!RESET)
    last_flag |=> done)
    else $error("no done cycle after the last lane");

endmodule

bind lane_streamer trigger_capture_chk u_chk (
  .CLK(CLK),
  .RESET(RESET),
  .fifo_push(1'b0),
  .fifo_full(1'b0),
  .first_flag(first_flag),
  .last_flag(last_flag),
  .done(done)
);

bind ptr_fifo trigger_capture_chk u_chk (
  .CLK(CLK),
  .RESET(RESET),
  .fifo_push(push),
  .fifo_full(full),
  .first_flag(1'b0),
  .last_flag(1'b0),
  .done(1'b1)
);

// File: verification/trigger_capture_tb.sv
`include "capture_settings.svh"

module trigger_capture_tb;
  import capture_pkg::*;

  localparam int NROWS = 6;

  // columns are idle writes before, window writes, writes after, drain first
  int rows [NROWS][4] = '{
    '{6, 5, 0, 0}, // full pre-trigger history
    '{2, 3, 0, 0}, // short history, queued behind row 0
    '{1, 2, 3, 0}, // queued too
    '{10, 6, 0, 1}, // crosses index 31 to 0
    '{2, 40, 0, 1}, // fills the ring, writes get dropped
    '{3, 2, 0, 1} // full has cleared again
  };

  logic CLK;
  logic RESET;
  logic we;
  logic trigger;
  logic [`CAP_DIN_WIDTH-1:0] din;
  lane_t dout;
  logic first_flag;
  logic last_flag;
  logic done;
  logic full;
  logic empty;

  logic [31:0] lfsr;
  sample_word_t mem_m [`CAP_RING_DEPTH];
  ring_ptr_t wr_m;
  ring_ptr_t rd_m;
  ring_ptr_t start_m;
  ring_ptr_t last_end_m;
  int since_end;
  logic trig_m;
  logic full_m;
  logic after_last;
  logic in_window; // lanes of one window come back to back
  lane_t exp_lane [$];
  logic exp_first [$];
  logic exp_last [$];

  trigger_capture uut (
    .CLK(CLK),
    .RESET(RESET),
    .we(we),
    .trigger(trigger),
    .din(din),
    .dout(dout),
    .first_flag(first_flag),
    .last_flag(last_flag),
    .done(done),
    .full(full),
    .empty(empty)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_lane(input string name, input lane_t got, input lane_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic sample_word_t take_random_word();
    sample_word_t w;
    int b;
    for (b = 0; b < `CAP_DIN_WIDTH; b++) begin
      w.raw[b] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
    return w;
  endfunction

  function automatic ring_ptr_t ring_add(input ring_ptr_t p, input int d);
    return ring_ptr_t'(((int'(p) + d) % `CAP_RING_DEPTH + `CAP_RING_DEPTH) % `CAP_RING_DEPTH);
  endfunction

  // start equal to end means the whole ring
  task automatic queue_window(input ring_ptr_t first_ptr, input ring_ptr_t end_ptr);
    int n;
    int k;
    int l;
    sample_word_t w;
    n = int'(ring_add(end_ptr, -int'(first_ptr) - 1)) + 1;
    for (k = 0; k < n; k++) begin
      w = mem_m[ring_add(first_ptr, k)];
      for (l = 0; l < `CAP_LANES; l++) begin
        exp_lane.push_back(w.lanes[l]);
        exp_first.push_back(k == 0 && l == 0);
        exp_last.push_back(k == n - 1 && l == `CAP_LANES - 1);
      end
    end
  endtask

  task automatic apply_cycle(input logic we_v, input logic trig_v);
    sample_word_t w;
    ring_ptr_t wr_next;
    logic accept;
    @(posedge CLK);
    #2;
    check_bit("full", full, full_m);
    w = take_random_word();
    we = we_v;
    trigger = trig_v;
    din = w.raw;
    wr_next = ring_add(wr_m, 1);
    accept = we_v && !full_m;
    if (trig_v && !trig_m) begin
      start_m = ring_add(wr_m, -since_end);
    end
    if (!trig_v && trig_m) begin
      queue_window(start_m, wr_m);
      last_end_m = wr_m;
      since_end = 0;
    end
    if (trig_m && wr_next == rd_m) begin
      full_m = 1'b1; // reader is parked at the last end
    end
    if (accept) begin
      mem_m[wr_m] = w;
      wr_m = wr_next;
      if (since_end < `CAP_PRE_LEN) begin
        since_end++;
      end
    end
    trig_m = trig_v;
  endtask

  task automatic wait_drained();
    while (exp_lane.size() != 0 || done !== 1'b1) begin
      @(negedge CLK);
    end
  endtask

  always @(negedge CLK) begin
    if (RESET === 1'b1) begin
      if (after_last) begin
        check_bit("done", done, 1'b1);
      end
      if (done === 1'b0) begin
        if (exp_lane.size() == 0) begin
          $display("a lane came out on dout while no window was expected");
          abort_run();
        end
        check_lane("dout", dout, exp_lane.pop_front());
        check_bit("first_flag", first_flag, exp_first.pop_front());
        check_bit("last_flag", last_flag, exp_last.pop_front());
        in_window = !last_flag;
      end else begin
        if (in_window) begin
          $display("done went high in the middle of a window");
          abort_run();
        end
        check_bit("first_flag", first_flag, 1'b0);
        check_bit("last_flag", last_flag, 1'b0);
      end
      after_last = last_flag && !done;
    end
  end

  initial begin
    int r;
    int limit;
    limit = 0;
    for (r = 0; r < NROWS; r++) begin
      limit += (rows[r][0] + rows[r][1] + rows[r][2] + 1) * 8;
    end
    repeat (limit + 4) @(posedge CLK);
    $display("timeout: stream not finished after %0d cycles", limit);
    abort_run();
  end

  initial begin
    int r;
    int i;
    lfsr = 32'h0ad74cdc;
    RESET = 1'b0;
    we = 1'b0;
    trigger = 1'b0;
    din = '0;
    wr_m = '0;
    rd_m = '0;
    start_m = '0;
    last_end_m = '0;
    since_end = 0;
    trig_m = 1'b0;
    full_m = 1'b0;
    after_last = 1'b0;
    in_window = 1'b0;
    repeat (4) @(posedge CLK);
    #2;
    RESET = 1'b1;
    check_bit("done", done, 1'b1);
    check_bit("first_flag", first_flag, 1'b0);
    check_bit("last_flag", last_flag, 1'b0);
    check_bit("full", full, 1'b0);
    check_bit("empty", empty, 1'b0);
    for (r = 0; r < NROWS; r++) begin
      if (rows[r][3] != 0) begin
        wait_drained();
        check_bit("empty", empty, wr_m == last_end_m); // reader rests at the last end
        rd_m = last_end_m;
        full_m = 1'b0; // nothing pending once drained
      end
      for (i = 0; i < rows[r][0]; i++) begin
        apply_cycle(1'b1, 1'b0);
      end
      for (i = 0; i < rows[r][1]; i++) begin
        apply_cycle(1'b1, 1'b1);
      end
      for (i = 0; i < rows[r][2]; i++) begin
        apply_cycle(1'b1, 1'b0);
      end
      apply_cycle(1'b0, 1'b0);
    end
    wait_drained();
    @(posedge CLK);
    #2;
    check_bit("empty", empty, wr_m == last_end_m);
    if (full === 1'b0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("full still set after every window was read");
      abort_run();
    end
  end

endmodule
